/* compile.f */
+incdir+hw
hw/decoderPkg.sv
hw/decodeOddball.sv
hw/decodeRegs.sv
hw/decodeImm.sv
hw/decodeStage.sv
dv/decodeStageTb.sv

/* dv/decodeStageTb.sv */
// Testbench for the instruction decode stage
// Random words through both four-phase handshakes, checked against a reference decode

`include "decoder_defines.svh"

module decodeStageTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ClkPeriod = 4;
	localparam int NumRandom = 2000;
	// Four RTD field values and five IRQ class values around the marked ones
	localparam int NumDirected = 9;
	localparam int NumTotal = NumDirected + NumRandom;
	localparam int StallEvery = 50;
	localparam int StallCycles = 30;
	// Budget of 20 cycles per instruction plus the reset stretch
	localparam int TimeoutNs = (NumTotal * 20 + 10) * ClkPeriod;

	logic clk;
	logic rstN;
	logic inReq;
	decoderPkg::instruction_t inInstr;
	logic inAck;
	logic outReq;
	logic outAck;
	decoderPkg::opcode_e outOpcode;
	decoderPkg::regNum_t outRd;
	decoderPkg::regNum_t outRs1;
	decoderPkg::regNum_t outRs2;
	logic outHasRd;
	decoderPkg::value_t outImm;
	logic outHasImm;
	logic outOddball;

	int seed;
	logic blockedSeen;

	// Words accepted by the DUT that have not shown up at the output yet
	logic [`INSTR_WIDTH-1:0] expected[$];

	decodeStage UUT
	(
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.inInstr(inInstr),
		.inAck(inAck),
		.outReq(outReq),
		.outAck(outAck),
		.outOpcode(outOpcode),
		.outRd(outRd),
		.outRs1(outRs1),
		.outRs2(outRs2),
		.outHasRd(outHasRd),
		.outImm(outImm),
		.outHasImm(outHasImm),
		.outOddball(outOddball)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	// ============================================================
	// Failure reporting and compare tasks
	// ============================================================

	task automatic stopRun();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic failWith(input string why);
		$display("%s", why);
		stopRun();
	endtask

	task automatic compareOpcode(input string name, input decoderPkg::opcode_e exp,
		input decoderPkg::opcode_e act);
		if (act !== exp)
		begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic compareReg(input string name, input decoderPkg::regNum_t exp,
		input decoderPkg::regNum_t act);
		if (act !== exp)
		begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic compareValue(input string name, input decoderPkg::value_t exp,
		input decoderPkg::value_t act);
		if (act !== exp)
		begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic compareFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("** Error: %s expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	// ============================================================
	// Reference decode
	// ============================================================

	// Checks one output word against the field rules of the instruction set
	task automatic checkDecode(input logic [`INSTR_WIDTH-1:0] w);
		decoderPkg::opcode_e op;
		logic immForm;
		decoderPkg::regNum_t rd;
		decoderPkg::regNum_t rs2;
		decoderPkg::value_t imm;
		logic odd;
		op = decoderPkg::opcode_e'(w[6:0]);
		immForm = op inside {decoderPkg::OP_ADDI, decoderPkg::OP_LOAD,
			decoderPkg::OP_STORE, decoderPkg::OP_BRANCH};
		rd = w[12:7];
		// Immediate forms have no second source
		rs2 = immForm ? '0 : w[24:19];
		imm = immForm ? decoderPkg::value_t'($signed(w[31:19])) : '0;
		odd = (op == decoderPkg::OP_SYS) || (op == decoderPkg::OP_CSR) ||
			(op == decoderPkg::OP_RTD && w[10:9] == 2'b01) ||
			(op == decoderPkg::OP_IRQ && w[25:22] == 4'd7);
		compareOpcode("outOpcode", op, outOpcode);
		compareReg("outRd", rd, outRd);
		compareReg("outRs1", w[18:13], outRs1);
		compareReg("outRs2", rs2, outRs2);
		// Register 0 is never written
		compareFlag("outHasRd", (op inside {decoderPkg::OP_ADD, decoderPkg::OP_ADDI,
			decoderPkg::OP_LOAD}) && (rd != '0), outHasRd);
		compareValue("outImm", imm, outImm);
		compareFlag("outHasImm", immForm, outHasImm);
		compareFlag("outOddball", odd, outOddball);
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	function automatic decoderPkg::opcode_e pickOpcode(input int sel);
		case (sel)
			0: return decoderPkg::OP_NOP;
			1: return decoderPkg::OP_ADD;
			2: return decoderPkg::OP_ADDI;
			3: return decoderPkg::OP_LOAD;
			4: return decoderPkg::OP_STORE;
			5: return decoderPkg::OP_BRANCH;
			6: return decoderPkg::OP_RTD;
			7: return decoderPkg::OP_SYS;
			8: return decoderPkg::OP_CSR;
			default: return decoderPkg::OP_IRQ;
		endcase
	endfunction

	// Mostly listed opcodes, about one word in six keeps its raw and probably illegal code
	function automatic logic [`INSTR_WIDTH-1:0] randomWord();
		logic [`INSTR_WIDTH-1:0] w;
		int sel;
		w = $random(seed);
		sel = $unsigned($random(seed)) % 12;
		if (sel < 10)
		begin
			w[6:0] = pickOpcode(sel);
		end
		// Push rd to zero now and then so the register-0 rule is exercised
		if ($unsigned($random(seed)) % 8 == 0)
		begin
			w[12:7] = '0;
		end
		return w;
	endfunction

	// One four-phase input transfer; the word is queued once the DUT has acked it
	task automatic sendWord(input logic [`INSTR_WIDTH-1:0] w);
		@(posedge clk);
		inReq <= 1'b1;
		inInstr <= w;
		do @(negedge clk); while (!inAck);
		@(posedge clk);
		inReq <= 1'b0;
		expected.push_back(w);
		do @(negedge clk); while (inAck);
	endtask

	task automatic produceAll();
		logic [`INSTR_WIDTH-1:0] w;
		// Return-from-interrupt marker and its neighbors
		for (int f = 0; f < 4; f++)
		begin
			w = randomWord();
			w[6:0] = decoderPkg::OP_RTD;
			w[10:9] = 2'(f);
			sendWord(w);
		end
		// REX class 7 and the classes next to it
		for (int f = 5; f < 10; f++)
		begin
			w = randomWord();
			w[6:0] = decoderPkg::OP_IRQ;
			w[25:22] = 4'(f);
			sendWord(w);
		end
		for (int n = 0; n < NumRandom; n++)
		begin
			sendWord(randomWord());
			repeat ($unsigned($random(seed)) % 3) @(posedge clk);
		end
	endtask

	// ============================================================
	// Consumer
	// ============================================================

	// While the output is held, the capture register is the only free slot
	task automatic checkBackPressure();
		int held;
		held = expected.size() + int'(inReq && inAck);
		if (held > 1)
		begin
			failWith("inAck rose for a third instruction while the output was held");
		end
		if (inReq && !inAck && expected.size() == 1)
		begin
			blockedSeen = 1'b1;
		end
	endtask

	task automatic consumeAll();
		logic stall;
		int d;
		for (int n = 0; n < NumTotal; n++)
		begin
			do @(negedge clk); while (!outReq);
			if (expected.size() == 0)
			begin
				failWith("outReq rose with no accepted instruction pending");
			end
			checkDecode(expected.pop_front());
			// Every so often hold the ack off long enough to fill both registers
			stall = (n % StallEvery) == StallEvery - 1;
			d = stall ? StallCycles : $unsigned($random(seed)) % 6;
			repeat (d)
			begin
				@(negedge clk);
				if (stall)
				begin
					checkBackPressure();
				end
			end
			@(posedge clk);
			outAck <= 1'b1;
			do @(negedge clk); while (outReq);
			@(posedge clk);
			outAck <= 1'b0;
		end
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================

	initial
	begin
		seed = 32'hc0928944;
		blockedSeen = 1'b0;
		rstN <= 1'b0;
		inReq <= 1'b0;
		inInstr <= '0;
		outAck <= 1'b0;
		// Both handshakes stay idle during reset
		repeat (10)
		begin
			@(negedge clk);
			compareFlag("inAck", 1'b0, inAck);
			compareFlag("outReq", 1'b0, outReq);
		end
		@(posedge clk);
		rstN <= 1'b1;
		fork
			produceAll();
			consumeAll();
		join
		// Nothing may come out twice
		repeat (20)
		begin
			@(negedge clk);
			if (outReq)
			begin
				failWith("outReq rose again after every instruction was checked");
			end
		end
		if (!blockedSeen)
		begin
			$display("Back-pressure never held off a third request");
			$display("Something failed");
			$fatal(1);
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

	initial
	begin
		#(TimeoutNs);
		$display("Run hung: timeout after %0d ns", TimeoutNs);
		stopRun();
	end

endmodule

/* hw/decodeImm.sv */
// Immediate decoder
// Sign-extends the immediate field for the opcodes that carry one

`include "decoder_defines.svh"

module decodeImm
(
	input decoderPkg::instruction_t instr,
	output decoderPkg::value_t imm,
	output logic hasImm
);

	// Copy of the field sign bit, replicated into the upper bits
	logic immSign;

	assign immSign = instr.ri.imm[`IMM_WIDTH-1];

	// Presence of an immediate depends only on the opcode
	always_comb
	begin
		case (instr.any.opcode)
			decoderPkg::OP_ADDI,
			decoderPkg::OP_LOAD,
			decoderPkg::OP_STORE,
			decoderPkg::OP_BRANCH:
			begin
				hasImm = 1'b1;
			end
			default:
			begin
				hasImm = 1'b0;
			end
		endcase
	end

	// ============================================================
	// Extension
	// ============================================================

	// Opcodes without an immediate present a clean zero downstream
	always_comb
	begin
		if (hasImm)
		begin
			imm = {{(`VALUE_WIDTH-`IMM_WIDTH){immSign}}, instr.ri.imm};
		end
		else
		begin
			imm = '0;
		end
	end

endmodule

/* hw/decodeOddball.sv */
// Oddball detector
// Flags instructions that only ALU #0 can execute

module decodeOddball
(
	input decoderPkg::instruction_t instr,
	output logic oddball
);

	// System-level work is restricted to the first ALU
	always_comb
	begin
		case (instr.any.opcode)
			// System calls and CSR accesses are always special
			decoderPkg::OP_SYS:
			begin
				oddball = 1'b1;
			end
			decoderPkg::OP_CSR:
			begin
				oddball = 1'b1;
			end
			// A return marked with 1 in bits 10..9 is a return from interrupt
			decoderPkg::OP_RTD:
			begin
				oddball = (instr[10:9] == 2'd1);
			end
			// Interrupt-class code 7 in bits 25..22 selects REX
			decoderPkg::OP_IRQ:
			begin
				oddball = (instr[25:22] == 4'h7);
			end
			// Everything else can issue on any ALU
			default:
			begin
				oddball = 1'b0;
			end
		endcase
	end

endmodule

/* hw/decodeRegs.sv */
// Register field decoder
// Pulls destination and source numbers out of the word and flags a real write

module decodeRegs
(
	input decoderPkg::instruction_t instr,
	output decoderPkg::regNum_t rd,
	output decoderPkg::regNum_t rs1,
	output decoderPkg::regNum_t rs2,
	output logic hasRd
);

	logic isImmForm;
	logic writesRd;

	// The immediate layout reuses the rs2 bits for the immediate
	always_comb
	begin
		case (instr.any.opcode)
			decoderPkg::OP_ADDI,
			decoderPkg::OP_LOAD,
			decoderPkg::OP_STORE,
			decoderPkg::OP_BRANCH:
			begin
				isImmForm = 1'b1;
			end
			default:
			begin
				isImmForm = 1'b0;
			end
		endcase
	end

	// Only arithmetic results and loads go back to the register file
	always_comb
	begin
		case (instr.any.opcode)
			decoderPkg::OP_ADD,
			decoderPkg::OP_ADDI,
			decoderPkg::OP_LOAD:
			begin
				writesRd = 1'b1;
			end
			default:
			begin
				writesRd = 1'b0;
			end
		endcase
	end

	// Both layouts keep rd and rs1 in the same bits
	assign rd = instr.rr.rd;
	assign rs1 = instr.rr.rs1;

	// Field selection by layout
	always_comb
	begin
		if (isImmForm)
		begin
			// No second source in this form
			rs2 = '0;
		end
		else
		begin
			rs2 = instr.rr.rs2;
		end
	end

	// Register 0 is hardwired, so a write to it is dropped here
	assign hasRd = writesRd && (rd != '0);

endmodule

/* hw/decodeStage.sv */
// Instruction decode stage
// Two-entry pipeline between four-phase req/ack handshakes on input and output

module decodeStage
(
	input logic clk,
	input logic rstN,

	input logic inReq,
	input decoderPkg::instruction_t inInstr,
	output logic inAck,

	output logic outReq,
	input logic outAck,
	output decoderPkg::opcode_e outOpcode,
	output decoderPkg::regNum_t outRd,
	output decoderPkg::regNum_t outRs1,
	output decoderPkg::regNum_t outRs2,
	output logic outHasRd,
	output decoderPkg::value_t outImm,
	output logic outHasImm,
	output logic outOddball
);

	// ============================================================
	// Capture register
	// ============================================================

	decoderPkg::instruction_t capInstr;
	logic capFull;

	// A new word is taken when the producer asserts a fresh request
	// and there is room for it
	logic capture;

	// The output side is idle once the consumer has finished its ack
	logic outFree;

	// The held word moves forward whenever the output side is idle
	logic transfer;

	assign capture = inReq && !inAck && !capFull;
	assign outFree = !outReq && !outAck;
	assign transfer = capFull && outFree;

	// Input handshake, ack rises with the capture edge
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			inAck <= 1'b0;
		end
		else if (capture)
		begin
			inAck <= 1'b1;
		end
		else if (!inReq)
		begin
			// Return to zero after the producer has withdrawn its request
			inAck <= 1'b0;
		end
	end

	// Occupancy of the capture register
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			capFull <= 1'b0;
		end
		else if (capture)
		begin
			capFull <= 1'b1;
		end
		else if (transfer)
		begin
			capFull <= 1'b0;
		end
	end

	// Held word, loaded together with inAck
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			capInstr <= inInstr;
		end
	end

	// ============================================================
	// Decoders
	// ============================================================

	decoderPkg::regNum_t decRd;
	decoderPkg::regNum_t decRs1;
	decoderPkg::regNum_t decRs2;
	decoderPkg::value_t decImm;
	logic decHasRd;
	logic decHasImm;
	logic decOddball;

	// All three work on the held word, so results are ready for the transfer
	decodeOddball uOddball
	(
		.instr(capInstr),
		.oddball(decOddball)
	);

	decodeRegs uRegs
	(
		.instr(capInstr),
		.rd(decRd),
		.rs1(decRs1),
		.rs2(decRs2),
		.hasRd(decHasRd)
	);

	decodeImm uImm
	(
		.instr(capInstr),
		.imm(decImm),
		.hasImm(decHasImm)
	);

	// ============================================================
	// Output register
	// ============================================================

	// Request rises with the loaded data and falls once the ack is seen
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			outReq <= 1'b0;
		end
		else if (transfer)
		begin
			outReq <= 1'b1;
		end
		else if (outAck)
		begin
			outReq <= 1'b0;
		end
	end

	// Decoded fields stay stable for the whole output handshake
	always_ff @(posedge clk)
	begin
		if (transfer)
		begin
			outOpcode <= capInstr.any.opcode;
			outRd <= decRd;
			outRs1 <= decRs1;
			outRs2 <= decRs2;
			outHasRd <= decHasRd;
			outImm <= decImm;
			outHasImm <= decHasImm;
			outOddball <= decOddball;
		end
	end

endmodule

/* hw/decoderPkg.sv */
// Shared decode types
// Opcode encoding and the field layouts of an instruction word

`include "decoder_defines.svh"

package decoderPkg;

	// ============================================================
	// Opcodes
	// ============================================================

	// Codes not listed here are illegal and decode as having no operands
	typedef enum logic [6:0]
	{
		OP_NOP    = 7'd0,
		OP_ADD    = 7'd2,
		OP_ADDI   = 7'd4,
		OP_LOAD   = 7'd16,
		OP_STORE  = 7'd18,
		OP_BRANCH = 7'd24,
		OP_RTD    = 7'd32,
		OP_SYS    = 7'd48,
		OP_CSR    = 7'd50,
		OP_IRQ    = 7'd52
	} opcode_e;

	// Architectural register number
	typedef logic [`REG_WIDTH-1:0] regNum_t;

	// Full-width data value
	typedef logic [`VALUE_WIDTH-1:0] value_t;

	// ============================================================
	// Field layouts
	// ============================================================

	// Opcode-only view, used before the format is known
	typedef struct packed
	{
		logic [`INSTR_WIDTH-8:0] payload;
		opcode_e opcode;
	} anyFmt_t;

	// Register-register form with two sources
	typedef struct packed
	{
		logic [`INSTR_WIDTH-3*`REG_WIDTH-8:0] pad;
		regNum_t rs2;
		regNum_t rs1;
		regNum_t rd;
		opcode_e opcode;
	} rrFmt_t;

	// Register-immediate form, the immediate sits where rs2 would be
	typedef struct packed
	{
		logic [`IMM_WIDTH-1:0] imm;
		regNum_t rs1;
		regNum_t rd;
		opcode_e opcode;
	} riFmt_t;

	// All layouts overlay the same word
	typedef union packed
	{
		anyFmt_t any;
		rrFmt_t rr;
		riFmt_t ri;
	} instruction_t;

endpackage

/* hw/decoder_defines.svh */
// Width macros for the instruction decode stage
// Instruction word, register number, raw immediate and data value widths

`ifndef DECODER_DEFINES_SVH
`define DECODER_DEFINES_SVH

// ============================================================
// Instruction word
// ============================================================

// Every instruction is one fixed-size word
`define INSTR_WIDTH 32

// ============================================================
// Fields and values
// ============================================================

// Register numbers address a 64-entry architectural file
`define REG_WIDTH 6

// Raw immediate field of the register-immediate layout
`define IMM_WIDTH 13

// Datapath width, which is also the width the immediate is extended to
`define VALUE_WIDTH 64

`endif

/* run.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
# The exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module decodeStageTb \
	--Mdir obj_dir -o decodeStageSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit "$status"
fi

./obj_dir/decodeStageSim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation returned status $status"
	exit "$status"
fi

exit 0
